// ==== tb.f ====
+incdir+verif
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/instr_fetch.sv
hdl/reg_file.sv
hdl/int_ops.sv
hdl/exec_unit.sv
hdl/cpu_top.sv
verif/tb_core.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - hdl/isa_pkg.sv
  - hdl/core_pkg.sv
  - hdl/instr_fetch.sv
  - hdl/reg_file.sv
  - hdl/int_ops.sv
  - hdl/exec_unit.sv
  - hdl/cpu_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_core.sv

// ==== verif/core_model.svh ====
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// ********************
// random programs
// ********************
localparam int RAND_LEN = 24;
// random part, register dump, halt
localparam int PROG_LEN = RAND_LEN + REG_N + 1;

instr_u prog_buf [PROG_LEN];

// instruction-level state of the reference
data_t ref_regs [REG_N];
flags_t ref_flags;

// expected output writes in program order
uob_addr_t exp_adr_q [$];
data_t exp_dat_q [$];

function automatic int rand_below(input int n);
	return $unsigned($random(seed)) % n;
endfunction

// half of the instructions run unconditionally
function automatic cond_e pick_cond();
	if (rand_below(2) == 0)
		return ALWAYS;
	return cond_e'(rand_below(8));
endfunction

function automatic void gen_program();
	instr_u w;
	int pick;
	for (int i = 0; i < RAND_LEN; i++) begin
		w = '0;
		pick = rand_below(14);
		w.alu.cond = pick_cond();
		w.alu.field_a = reg_addr_t'(rand_below(REG_N));
		w.alu.field_b = reg_addr_t'(rand_below(REG_N));
		w.alu.imm = data_t'($random(seed));
		// small constants make zero and borrow results common
		if (rand_below(3) == 0)
			w.alu.imm = w.alu.imm & 16'h000f;
		case (pick)
			8: begin
				w.alu.opcode = FLAG;
				w.alu.imm = data_t'(rand_below(4));
			end
			9, 10: begin
				// forward only, at most onto the first dump write
				w.jmp.opcode = JMP;
				w.jmp.target = pc_t'(i + 1 + rand_below(RAND_LEN - i));
				w.jmp.rsvd = '0;
			end
			11: begin
				w.alu.opcode = MV_UOB_R;
				// kept above the dump addresses
				w.alu.imm = data_t'(8 + rand_below(56));
			end
			default: w.alu.opcode = opcode_e'(pick % 8);
		endcase
		prog_buf[i] = w;
	end
	// each register to its own output address
	for (int r = 0; r < REG_N; r++) begin
		w = '0;
		w.alu.opcode = MV_UOB_R;
		w.alu.cond = ALWAYS;
		w.alu.field_a = reg_addr_t'(r);
		w.alu.imm = data_t'(r);
		prog_buf[RAND_LEN + r] = w;
	end
	w = '0;
	w.jmp.opcode = HALT;
	w.jmp.cond = ALWAYS;
	prog_buf[PROG_LEN - 1] = w;
endfunction

// ********************
// reference model
// ********************
function automatic bit cond_holds(input cond_e c);
	bit t;
	case (c)
		IF_ZERO:     t = ref_flags.zero;
		IF_NZERO:    t = !ref_flags.zero;
		IF_CARRY:    t = ref_flags.carry;
		IF_NCARRY:   t = !ref_flags.carry;
		IF_OVERFLOW: t = ref_flags.overflow;
		IF_USER:     t = ref_flags.user;
		IF_NUSER:    t = !ref_flags.user;
		default:     t = 1'b1;
	endcase
	return t;
endfunction

// add or subtract in plain integers, carry is the borrow when subtracting
function automatic data_t arith_result(input data_t a, input data_t b,
	input bit with_carry, input bit subtract);
	int cin;
	int ua;
	int sa;
	data_t r;
	cin = (with_carry && ref_flags.carry) ? 1 : 0;
	if (subtract) begin
		ua = int'(a) - int'(b) - cin;
		sa = int'($signed(a)) - int'($signed(b)) - cin;
	end else begin
		ua = int'(a) + int'(b) + cin;
		sa = int'($signed(a)) + int'($signed(b)) + cin;
	end
	r = ua[15:0];
	ref_flags.zero = (r == '0);
	ref_flags.carry = subtract ? (ua < 0) : (ua > 65535);
	// signed result out of 16-bit range
	ref_flags.overflow = (sa > 32767) || (sa < -32768);
	return r;
endfunction

function automatic void run_model();
	instr_u w;
	data_t a;
	data_t r;
	int pc;
	int steps;
	bit done;
	pc = 0;
	steps = 0;
	done = 1'b0;
	while (!done && pc < PROG_LEN && steps < 4 * PROG_LEN) begin
		w = prog_buf[pc];
		steps++;
		pc++;
		if (cond_holds(w.alu.cond)) begin
			a = ref_regs[w.alu.field_a];
			case (w.alu.opcode)
				ADD_R_C:  ref_regs[w.alu.field_b] = arith_result(a, w.alu.imm, 1'b0, 1'b0);
				SUB_R_C:  ref_regs[w.alu.field_b] = arith_result(a, w.alu.imm, 1'b0, 1'b1);
				ADDC_R_C: ref_regs[w.alu.field_b] = arith_result(a, w.alu.imm, 1'b1, 1'b0);
				SUBB_R_C: ref_regs[w.alu.field_b] = arith_result(a, w.alu.imm, 1'b1, 1'b1);
				MV_R_C:   ref_regs[w.alu.field_b] = w.alu.imm;
				MV_R_R:   ref_regs[w.alu.field_b] = a;
				AND_R_C: begin
					r = a & w.alu.imm;
					ref_flags.zero = (r == '0);
					ref_regs[w.alu.field_b] = r;
				end
				SHR1: begin
					ref_flags.carry = a[0];
					r = a >> 1;
					ref_flags.zero = (r == '0);
					ref_regs[w.alu.field_b] = r;
				end
				FLAG: begin
					case (w.alu.imm[1:0])
						FLAG_SET:    ref_flags.user = 1'b1;
						FLAG_CLEAR:  ref_flags.user = 1'b0;
						FLAG_TOGGLE: ref_flags.user = !ref_flags.user;
						default: ;
					endcase
				end
				JMP:  pc = int'(w.jmp.target);
				HALT: done = 1'b1;
				MV_UOB_R: begin
					exp_adr_q.push_back(w.alu.imm[UOB_ADDR_W-1:0]);
					exp_dat_q.push_back(a);
				end
				default: ;
			endcase
		end
	end
endfunction

`endif

// ==== verif/tb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core;
	import core_pkg::*;
	import isa_pkg::*;

	localparam int N_PROGS = 20;
	localparam int HALT_TIMEOUT = 2000;
	localparam int QUIET_CYCLES = 10;

	logic CLK;
	logic reset;
	logic start;
	logic prog_wr_en;
	pc_t prog_addr;
	instr_u prog_data;
	logic halted;
	logic uob_cyc;
	logic uob_stb;
	logic uob_we;
	uob_addr_t uob_adr;
	data_t uob_dat;
	logic uob_ack;

	integer seed;
	int err_mismatch;
	int err_timeout;
	int err_other;
	bit timed_out;

	`include "core_model.svh"

	cpu_top dut (
		.CLK        (CLK),
		.reset      (reset),
		.start      (start),
		.prog_wr_en (prog_wr_en),
		.prog_addr  (prog_addr),
		.prog_data  (prog_data),
		.halted     (halted),
		.uob_cyc    (uob_cyc),
		.uob_stb    (uob_stb),
		.uob_we     (uob_we),
		.uob_adr    (uob_adr),
		.uob_dat    (uob_dat),
		.uob_ack    (uob_ack)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// ********************
	// compare tasks
	// ********************
	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			err_mismatch++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input uob_addr_t got, input uob_addr_t exp);
		if (got !== exp) begin
			err_mismatch++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_halted(input string name, input bit got, input bit exp);
		if (got !== exp) begin
			err_mismatch++;
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// ********************
	// program load and run control
	// ********************
	task automatic load_program();
		for (int a = 0; a < PROG_LEN; a++) begin
			@(posedge CLK);
			prog_wr_en <= 1'b1;
			prog_addr <= pc_t'(a);
			prog_data <= prog_buf[a];
		end
		@(posedge CLK);
		prog_wr_en <= 1'b0;
	endtask

	task automatic pulse_start();
		@(posedge CLK);
		start <= 1'b1;
		@(posedge CLK);
		start <= 1'b0;
		@(negedge CLK);
		check_halted("halted", halted, 1'b0);
	endtask

	task automatic wait_halted();
		int cycles;
		cycles = 0;
		@(negedge CLK);
		while (!halted && cycles < HALT_TIMEOUT) begin
			@(negedge CLK);
			cycles++;
		end
		if (!halted) begin
			err_timeout++;
			timed_out = 1'b1;
			$display("timeout: core did not halt within %0d cycles", HALT_TIMEOUT);
		end
	endtask

	// halted core must leave the bus idle
	task automatic check_quiet();
		for (int i = 0; i < QUIET_CYCLES; i++) begin
			@(negedge CLK);
			if (uob_cyc || uob_stb) begin
				err_other++;
				$display("bus cycle started after halt");
			end
		end
		check_halted("halted", halted, 1'b1);
	endtask

	task automatic report_and_finish();
		$display("errors: %0d mismatch, %0d timeout, %0d other",
			err_mismatch, err_timeout, err_other);
		if (err_mismatch + err_timeout + err_other == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	endtask

	// ********************
	// wishbone slave
	// ********************
	// sample at negedge, ack after 0 to 5 cycles, one transfer per cycle
	initial begin : wb_slave
		int delay;
		forever begin
			@(negedge CLK);
			if (uob_cyc && uob_stb) begin
				if (!uob_we) begin
					err_other++;
					$display("bus cycle without write enable");
				end
				delay = rand_below(6);
				repeat (delay) @(negedge CLK);
				if (exp_adr_q.size() == 0) begin
					err_other++;
					$display("unexpected output write to address %h", uob_adr);
				end else begin
					check_addr("uob_adr", uob_adr, exp_adr_q.pop_front());
					check_data("uob_dat", uob_dat, exp_dat_q.pop_front());
				end
				@(posedge CLK);
				uob_ack <= 1'b1;
				@(posedge CLK);
				uob_ack <= 1'b0;
			end
		end
	end

	// ********************
	// main sequence
	// ********************
	initial begin
		reset = 1'b1;
		start = 1'b0;
		prog_wr_en = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		uob_ack = 1'b0;
		seed = 68;
		err_mismatch = 0;
		err_timeout = 0;
		err_other = 0;
		timed_out = 1'b0;
		ref_flags = '0;
		for (int r = 0; r < REG_N; r++)
			ref_regs[r] = '0;
		repeat (16) @(posedge CLK);
		reset <= 1'b0;
		// idle until the first start
		repeat (4) begin
			@(negedge CLK);
			check_halted("halted", halted, 1'b0);
			if (uob_cyc || uob_stb) begin
				err_other++;
				$display("bus cycle active before start");
			end
		end
		// registers and flags carry over from one program to the next
		for (int p = 0; p < N_PROGS && !timed_out; p++) begin
			exp_adr_q.delete();
			exp_dat_q.delete();
			gen_program();
			run_model();
			load_program();
			pulse_start();
			wait_halted();
			if (!timed_out) begin
				if (exp_adr_q.size() != 0) begin
					err_other++;
					$display("program %0d: %0d expected output writes never appeared",
						p, exp_adr_q.size());
				end
				check_quiet();
			end
		end
		report_and_finish();
	end

endmodule

`default_nettype wire

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input  logic                 CLK,
	input  logic                 reset,
	input  logic                 start,
	input  logic                 prog_wr_en,
	input  core_pkg::pc_t        prog_addr,
	input  isa_pkg::instr_u      prog_data,
	output logic                 halted,
	output logic                 uob_cyc,
	output logic                 uob_stb,
	output logic                 uob_we,
	output core_pkg::uob_addr_t  uob_adr,
	output core_pkg::data_t      uob_dat,
	input  logic                 uob_ack
);
	import core_pkg::*;
	import isa_pkg::*;

	// ********************
	// fetch to execute, register file ports
	// ********************
	logic issue_valid;
	instr_u issue_instr;
	logic rd_en;
	reg_addr_t rd_addr;
	data_t rd_data;
	logic wr_en;
	reg_addr_t wr_addr;
	data_t wr_data;
	// execute back to fetch
	logic retire;
	logic jump;
	pc_t jump_target;
	logic halt_req;

	instr_fetch u_instr_fetch (.*);

	reg_file u_reg_file (.*);

	exec_unit u_exec_unit (.*);

endmodule

`default_nettype wire

// ==== hdl/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input  logic                 CLK,
	input  logic                 reset,
	input  logic                 issue_valid,
	input  isa_pkg::instr_u      issue_instr,
	input  core_pkg::data_t      rd_data,
	output logic                 wr_en,
	output core_pkg::reg_addr_t  wr_addr,
	output core_pkg::data_t      wr_data,
	output logic                 retire,
	output logic                 jump,
	output core_pkg::pc_t        jump_target,
	output logic                 halt_req,
	output logic                 uob_cyc,
	output logic                 uob_stb,
	output logic                 uob_we,
	output core_pkg::uob_addr_t  uob_adr,
	output core_pkg::data_t      uob_dat,
	input  logic                 uob_ack
);
	import core_pkg::*;
	import isa_pkg::*;

	instr_u instr_q;
	// operand is on rd_data while ex_valid
	logic ex_valid;
	flags_t flags_r;
	flags_t flags_new;
	data_t alu_result;
	logic cond_true;
	logic writes_reg;
	logic bus_start;
	logic ack_q;

	always_ff @(posedge CLK) begin
		if (reset)
			ex_valid <= 1'b0;
		else
			ex_valid <= issue_valid;
	end

	always_ff @(posedge CLK) begin
		if (issue_valid)
			instr_q <= issue_instr;
	end

	int_ops u_int_ops (
		.op        (instr_q.alu.opcode),
		.opnd      (rd_data),
		.imm       (instr_q.alu.imm),
		.flags_in  (flags_r),
		.result    (alu_result),
		.flags_out (flags_new)
	);

	// ********************
	// condition check
	// ********************
	always_comb begin
		case (instr_q.alu.cond)
			IF_ZERO:     cond_true = flags_r.zero;
			IF_NZERO:    cond_true = ~flags_r.zero;
			IF_CARRY:    cond_true = flags_r.carry;
			IF_NCARRY:   cond_true = ~flags_r.carry;
			IF_OVERFLOW: cond_true = flags_r.overflow;
			IF_USER:     cond_true = flags_r.user;
			IF_NUSER:    cond_true = ~flags_r.user;
			default:     cond_true = 1'b1;
		endcase
	end

	assign writes_reg = instr_q.alu.opcode inside {ADD_R_C, SUB_R_C, ADDC_R_C, SUBB_R_C,
		MV_R_C, AND_R_C, SHR1, MV_R_R};

	// flags follow every executed instruction, int_ops keeps the rest
	always_ff @(posedge CLK) begin
		if (reset)
			flags_r <= '0;
		else if (ex_valid && cond_true)
			flags_r <= flags_new;
	end

	// ********************
	// write-back, jump, halt
	// ********************
	assign wr_en = ex_valid & cond_true & writes_reg;
	assign wr_addr = instr_q.alu.field_b;
	assign wr_data = alu_result;

	assign jump = ex_valid & cond_true & (instr_q.jmp.opcode == JMP);
	assign jump_target = instr_q.jmp.target;
	assign halt_req = ex_valid & cond_true & (instr_q.jmp.opcode == HALT);

	// output retires after ack, everything else right away
	assign bus_start = ex_valid & cond_true & (instr_q.alu.opcode == MV_UOB_R);
	assign retire = (ex_valid & ~bus_start) | ack_q;

	// ********************
	// wishbone classic write master
	// ********************
	always_ff @(posedge CLK) begin
		if (reset) begin
			uob_cyc <= 1'b0;
			uob_stb <= 1'b0;
			uob_we <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			ack_q <= uob_cyc & uob_ack;
			if (uob_cyc && uob_ack) begin
				uob_cyc <= 1'b0;
				uob_stb <= 1'b0;
				uob_we <= 1'b0;
			end else if (bus_start) begin
				uob_cyc <= 1'b1;
				uob_stb <= 1'b1;
				uob_we <= 1'b1;
			end
		end
	end

	// address and data held for the whole transfer
	always_ff @(posedge CLK) begin
		if (bus_start) begin
			uob_adr <= instr_q.alu.imm[UOB_ADDR_W-1:0];
			uob_dat <= rd_data;
		end
	end

	a_stb_in_cyc: assert property (@(posedge CLK) disable iff (reset)
		uob_stb |-> uob_cyc);

	a_wb_stable: assert property (@(posedge CLK) disable iff (reset)
		(uob_stb && !uob_ack) |=> ($stable(uob_adr) && $stable(uob_dat)));

endmodule

`default_nettype wire

// ==== hdl/int_ops.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_ops (
	input  isa_pkg::opcode_e  op,
	input  core_pkg::data_t   opnd,
	input  core_pkg::data_t   imm,
	input  isa_pkg::flags_t   flags_in,
	output core_pkg::data_t   result,
	output isa_pkg::flags_t   flags_out
);
	import core_pkg::*;
	import isa_pkg::*;

	logic cin;
	// extra msb holds carry out or borrow
	logic [DATA_W:0] sum;
	logic [DATA_W:0] diff;
	logic add_ovf;
	logic sub_ovf;

	// carry-using forms only
	assign cin = (op == ADDC_R_C || op == SUBB_R_C) ? flags_in.carry : 1'b0;

	assign sum = {1'b0, opnd} + {1'b0, imm} + cin;
	assign diff = {1'b0, opnd} - {1'b0, imm} - cin;

	// signed overflow
	assign add_ovf = (opnd[DATA_W-1] == imm[DATA_W-1]) && (sum[DATA_W-1] != opnd[DATA_W-1]);
	assign sub_ovf = (opnd[DATA_W-1] != imm[DATA_W-1]) && (diff[DATA_W-1] != opnd[DATA_W-1]);

	always_comb begin
		result = opnd;
		flags_out = flags_in;
		case (op)
			ADD_R_C, ADDC_R_C: begin
				result = sum[DATA_W-1:0];
				flags_out.zero = (result == '0);
				flags_out.carry = sum[DATA_W];
				flags_out.overflow = add_ovf;
			end
			SUB_R_C, SUBB_R_C: begin
				result = diff[DATA_W-1:0];
				flags_out.zero = (result == '0);
				flags_out.carry = diff[DATA_W];
				flags_out.overflow = sub_ovf;
			end
			MV_R_C:
				result = imm;
			AND_R_C: begin
				result = opnd & imm;
				flags_out.zero = (result == '0);
			end
			SHR1: begin
				result = {1'b0, opnd[DATA_W-1:1]};
				// bit shifted out
				flags_out.carry = opnd[0];
				flags_out.zero = (result == '0);
			end
			FLAG: begin
				case (imm[1:0])
					FLAG_SET:    flags_out.user = 1'b1;
					FLAG_CLEAR:  flags_out.user = 1'b0;
					FLAG_TOGGLE: flags_out.user = ~flags_in.user;
					default:     flags_out.user = flags_in.user;
				endcase
			end
			// MV_R_R, jump, halt, output: no change
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                 CLK,
	input  logic                 reset,
	input  logic                 rd_en,
	input  core_pkg::reg_addr_t  rd_addr,
	output core_pkg::data_t      rd_data,
	input  logic                 wr_en,
	input  core_pkg::reg_addr_t  wr_addr,
	input  core_pkg::data_t      wr_data
);
	import core_pkg::*;

	data_t regs [REG_N];

	// ********************
	// write port
	// ********************
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < REG_N; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// ********************
	// registered read port
	// ********************
	// same-cycle write is not seen, old value returned
	always_ff @(posedge CLK) begin
		if (rd_en)
			rd_data <= regs[rd_addr];
	end

	// issue waits for retire, so the ports never collide
	a_no_rd_wr_overlap: assert property (@(posedge CLK) disable iff (reset)
		!(rd_en && wr_en));

endmodule

`default_nettype wire

// ==== hdl/instr_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_fetch (
	input  logic                 CLK,
	input  logic                 reset,
	input  logic                 start,
	input  logic                 prog_wr_en,
	input  core_pkg::pc_t        prog_addr,
	input  isa_pkg::instr_u      prog_data,
	input  logic                 retire,
	input  logic                 jump,
	input  core_pkg::pc_t        jump_target,
	input  logic                 halt_req,
	output logic                 issue_valid,
	output isa_pkg::instr_u      issue_instr,
	output logic                 rd_en,
	output core_pkg::reg_addr_t  rd_addr,
	output logic                 halted
);
	import core_pkg::*;
	import isa_pkg::*;

	instr_u prog_mem [PROG_DEPTH];
	pc_t pc;
	instr_u pf_instr;
	logic pf_valid;
	logic running;
	// one instruction between issue and retire
	logic busy;
	logic redirect;
	logic issue_now;
	logic fetch_now;

	// taken jump, prefetched word is stale
	assign redirect = retire & jump;

	// issue only once the previous instruction has retired
	assign issue_now = running & ~halt_req & ~redirect & pf_valid & (~busy | retire);
	// refill while empty or being emptied
	assign fetch_now = running & ~halt_req & ~redirect & (~pf_valid | issue_now);

	// ********************
	// program memory, read lands in the prefetch register
	// ********************
	always_ff @(posedge CLK) begin
		if (prog_wr_en && !running)
			prog_mem[prog_addr] <= prog_data;
		if (fetch_now)
			pf_instr <= prog_mem[pc];
	end

	always_ff @(posedge CLK) begin
		if (issue_now)
			issue_instr <= pf_instr;
	end

	// ********************
	// pc and run state
	// ********************
	always_ff @(posedge CLK) begin
		if (reset) begin
			running <= 1'b0;
			halted <= 1'b0;
			pc <= '0;
			pf_valid <= 1'b0;
			busy <= 1'b0;
			issue_valid <= 1'b0;
		end else if (start) begin
			running <= 1'b1;
			halted <= 1'b0;
			pc <= '0;
			pf_valid <= 1'b0;
			busy <= 1'b0;
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= issue_now;
			if (halt_req) begin
				running <= 1'b0;
				halted <= 1'b1;
				pf_valid <= 1'b0;
				busy <= 1'b0;
			end else if (redirect) begin
				// refetch from the target next cycle
				pc <= jump_target;
				pf_valid <= 1'b0;
				busy <= 1'b0;
			end else begin
				if (issue_now)
					busy <= 1'b1;
				else if (retire)
					busy <= 1'b0;
				if (fetch_now) begin
					pf_valid <= 1'b1;
					pc <= pc + 1'b1;
				end else if (issue_now) begin
					pf_valid <= 1'b0;
				end
			end
		end
	end

	// operand read goes out together with the issue
	assign rd_en = issue_valid;
	assign rd_addr = issue_instr.alu.field_a;

	// a halted core stays quiet until the next start
	a_no_issue_halted: assert property (@(posedge CLK) disable iff (reset)
		issue_valid |-> !halted);

endmodule

`default_nettype wire

// ==== hdl/core_pkg.sv ====
`default_nettype none

package core_pkg;

	// ********************
	// datapath
	// ********************
	localparam int DATA_W = 16;
	typedef logic [DATA_W-1:0] data_t;

	// register file, 8 entries
	localparam int REG_N = 8;
	typedef logic [$clog2(REG_N)-1:0] reg_addr_t;

	// ********************
	// program and output space
	// ********************
	localparam int PROG_DEPTH = 256;
	typedef logic [$clog2(PROG_DEPTH)-1:0] pc_t;

	// output buffer address, low bits of imm
	localparam int UOB_ADDR_W = 6;
	typedef logic [UOB_ADDR_W-1:0] uob_addr_t;

endpackage

`default_nettype wire

// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	// ********************
	// instruction word layout
	// ********************
	localparam int INSTR_W = 32;
	localparam int OPC_W = 4;
	localparam int COND_W = 3;
	// register select fields
	localparam int RSEL_W = 3;
	localparam int IMM_W = 16;
	// jump target, program address
	localparam int TGT_W = 8;
	localparam int ALU_RSVD_W = INSTR_W - OPC_W - COND_W - 2 * RSEL_W - IMM_W;
	localparam int JMP_RSVD_W = INSTR_W - OPC_W - COND_W - TGT_W;

	// operation codes
	typedef enum logic [OPC_W-1:0] {
		ADD_R_C  = 4'd0,
		SUB_R_C  = 4'd1,
		ADDC_R_C = 4'd2,
		SUBB_R_C = 4'd3,
		MV_R_C   = 4'd4,
		AND_R_C  = 4'd5,
		SHR1     = 4'd6,
		MV_R_R   = 4'd7,
		FLAG     = 4'd8,
		JMP      = 4'd9,
		HALT     = 4'd10,
		MV_UOB_R = 4'd11
	} opcode_e;

	// per-instruction condition, checked against the flags register
	typedef enum logic [COND_W-1:0] {
		ALWAYS      = 3'd0,
		IF_ZERO     = 3'd1,
		IF_NZERO    = 3'd2,
		IF_CARRY    = 3'd3,
		IF_NCARRY   = 3'd4,
		IF_OVERFLOW = 3'd5,
		IF_USER     = 3'd6,
		IF_NUSER    = 3'd7
	} cond_e;

	// flags, zero at the msb
	typedef struct packed {
		logic zero;
		logic overflow;
		// borrow on subtraction
		logic carry;
		logic user;
	} flags_t;

	// user flag codes in imm[1:0] of FLAG
	localparam logic [1:0] FLAG_KEEP = 2'b00;
	localparam logic [1:0] FLAG_SET = 2'b01;
	localparam logic [1:0] FLAG_CLEAR = 2'b10;
	localparam logic [1:0] FLAG_TOGGLE = 2'b11;

	// ********************
	// the two decodings of one word
	// ********************

	// integer ops and output: src field_a, dst field_b
	typedef struct packed {
		opcode_e                opcode;
		cond_e                  cond;
		logic [RSEL_W-1:0]      field_a;
		logic [RSEL_W-1:0]      field_b;
		logic [ALU_RSVD_W-1:0]  rsvd;
		logic [IMM_W-1:0]       imm;
	} instr_alu_t;

	// jump and halt
	typedef struct packed {
		opcode_e                opcode;
		cond_e                  cond;
		logic [TGT_W-1:0]       target;
		logic [JMP_RSVD_W-1:0]  rsvd;
	} instr_jmp_t;

	typedef union packed {
		instr_alu_t  alu;
		instr_jmp_t  jmp;
	} instr_u;

endpackage

`default_nettype wire
